/* compile.f */
rtl/cop_pkg.sv
rtl/cop_decode.sv
rtl/cop_execute.sv
rtl/cop_result.sv
rtl/cop_retire_check.sv
rtl/cop_top.sv
sim/tb_clock_gen.sv
sim/tb_cop_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds the coprocessor testbench with Verilator and runs it.
# Exits non-zero unless the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_cop_top -o sim_cop
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_cop)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1

/* sim/cop_patterns.txt */
// enc      rs1      result wen waddr wdata    bad_ins_count
// result 0 is SUCCESS, 2 is BAD_INS
0000008B 12345678 0 0 00 00000000 0000
0000928B 00000000 0 1 05 12345678 0000
0000010B F0000001 0 0 00 00000000 0000
0000018B 20000005 0 0 00 00000000 0000
0031220B 00000000 0 0 00 00000000 0000
0031330B 00000000 0 0 00 00000000 0000
0002150B 00000000 0 1 0A 10000006 0000
0003158B 00000000 0 1 0B D0000004 0000
0000038B 80000003 0 0 00 00000000 0000
0003C40B 00000000 0 0 00 00000000 0000
0013C48B 00000000 0 0 00 00000000 0000
01F3C60B 00000000 0 0 00 00000000 0000
0004108B 00000000 0 1 01 80000003 0000
0004910B 00000000 0 1 02 C0000001 0000
0006118B 00000000 0 1 03 00000007 0000
000000B3 DEADBEEF 2 0 00 00000000 0001
0000510B CAFEF00D 2 0 00 00000000 0002
0231218B 00000000 2 0 00 00000000 0003
0203C08B 00000000 2 0 00 00000000 0004
0000920B 00000000 0 1 04 12345678 0004
0001128B 00000000 0 1 05 F0000001 0004
0001930B 00000000 0 1 06 20000005 0004

/* sim/tb_cop_top.sv */
/*
 * Testbench for the coprocessor slice.
 * Streams the instructions from the pattern file back to back and checks
 * every retirement trace, its latency, the BAD_INS count and the fault flag.
 */
`timescale 1ns/10ps

module tb_cop_top;
    import cop_pkg::*;

    localparam int num_patterns = 22;
    localparam int num_fields   = 7;
    localparam int num_words    = num_patterns * num_fields;

    // Marks words that the pattern file did not load
    localparam logic [31:0] fill_base = 32'hf111_0000;

    logic                vtx_clk;
    logic                reset;
    logic                instr_valid;
    logic [31:0]         instr_enc;
    logic [31:0]         instr_rs1;
    cop_pkg::cop_trace_t trace;
    logic                check_fault;
    logic [15:0]         bad_ins_count;

    // Per line: enc, rs1, result, wen, waddr, wdata, bad_ins_count after retire
    logic [31:0] pat_mem [0:num_words-1];

    int pat_q [$];
    int due_q [$];
    int cycle_count = 0;
    int error_count = 0;
    int check_count = 0;

    tb_clock_gen u_clock_gen (
        .vtx_clk (vtx_clk),
        .reset   (reset)
    );

    cop_top u_dut (
        .vtx_clk       (vtx_clk),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .instr_enc     (instr_enc),
        .instr_rs1     (instr_rs1),
        .trace         (trace),
        .check_fault   (check_fault),
        .bad_ins_count (bad_ins_count)
    );

    always @(posedge vtx_clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic compare_word(input string where, input string name,
                                input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("Error: %s at %s expected %h got %h", name, where, exp, got);
        end
    endtask

    // Traces are sampled half a cycle after the edge that produced them
    always @(negedge vtx_clk) begin : trace_monitor
        int    idx;
        int    due;
        int    base;
        string where;
        if (!reset && trace.valid) begin
            if (pat_q.size() == 0) begin
                error_count++;
                $display("A trace retired with no instruction in flight, cycle %0d",
                         cycle_count);
            end else begin
                idx   = pat_q.pop_front();
                due   = due_q.pop_front();
                base  = idx * num_fields;
                where = $sformatf("pattern %0d", idx);
                compare_word(where, "trace.result", 32'(trace.result), pat_mem[base+2]);
                compare_word(where, "trace.wen", 32'(trace.wen), pat_mem[base+3]);
                compare_word(where, "trace.waddr", 32'(trace.waddr), pat_mem[base+4]);
                compare_word(where, "trace.wdata", trace.wdata, pat_mem[base+5]);
                // Only a rejected encoding retires as BAD_INS
                compare_word(where, "trace.invalid", 32'(trace.invalid),
                             (pat_mem[base+2] == 32'(BAD_INS)) ? 32'd1 : 32'd0);
                compare_word(where, "retire cycle", cycle_count, due);
                // Counter lags the trace by one edge
                compare_word(where, "bad_ins_count", 32'(bad_ins_count),
                             (idx == 0) ? 32'd0 : pat_mem[base-1]);
                compare_word(where, "check_fault", 32'(check_fault), 32'd0);
            end
        end
    end

    initial begin
        int wait_cycles;
        int invalid_total;
        instr_valid = 1'b0;
        instr_enc   = 32'd0;
        instr_rs1   = 32'd0;
        for (int i = 0; i < num_words; i++) begin
            pat_mem[i] = fill_base ^ 32'(i);
        end
        $readmemh("sim/cop_patterns.txt", pat_mem);
        if (pat_mem[num_words-1] == (fill_base ^ 32'(num_words-1))) begin
            error_count++;
            $display("The pattern file is missing or shorter than expected");
        end

        wait_cycles = 0;
        do begin
            @(posedge vtx_clk);
            wait_cycles++;
        end while (reset && wait_cycles < 20);

        if (reset) begin
            error_count++;
            $display("Timed out waiting for reset to be released");
        end else begin
            for (int k = 0; k < num_patterns; k++) begin
                @(posedge vtx_clk);
                #2;
                instr_valid = 1'b1;
                instr_enc   = pat_mem[k*num_fields];
                instr_rs1   = pat_mem[k*num_fields+1];
                pat_q.push_back(k);
                // Retires after the third edge following this one
                due_q.push_back(cycle_count + 3);
            end
            @(posedge vtx_clk);
            #2;
            instr_valid = 1'b0;
            instr_enc   = 32'd0;
            instr_rs1   = 32'd0;

            wait_cycles = 0;
            while (pat_q.size() != 0 && wait_cycles < 10) begin
                @(negedge vtx_clk);
                wait_cycles++;
            end

            if (pat_q.size() != 0) begin
                error_count++;
                $display("Timed out waiting for %0d instructions to retire", pat_q.size());
            end else begin
                @(negedge vtx_clk);
                invalid_total = 0;
                for (int k = 0; k < num_patterns; k++) begin
                    if (pat_mem[k*num_fields+2] == 32'(BAD_INS)) begin
                        invalid_total++;
                    end
                end
                compare_word("end of run", "bad_ins_count", 32'(bad_ins_count),
                             invalid_total);
                compare_word("end of run", "bad_ins_count", 32'(bad_ins_count),
                             pat_mem[num_words-1]);
                compare_word("end of run", "check_fault", 32'(check_fault), 32'd0);
            end
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* sim/tb_clock_gen.sv */
/*
 * Clock and reset source for the coprocessor testbench.
 * 20 ns clock, reset high for the first four rising edges.
 */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic vtx_clk,
    output logic reset
);

    initial begin
        vtx_clk = 1'b0;
        forever #10 vtx_clk = ~vtx_clk;
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge vtx_clk);
        #2 reset = 1'b0;
    end

endmodule

/* rtl/cop_top.sv */
/*
 * Top level of the coprocessor slice.
 * Chains decode, execute and result, so an instruction retires three
 * edges after it is presented, and feeds the trace to the checker.
 */
`timescale 1ns/10ps

module cop_top (
    input  logic                vtx_clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  logic [31:0]         instr_enc,
    input  logic [31:0]         instr_rs1,
    output cop_pkg::cop_trace_t trace,
    output logic                check_fault,
    output logic [15:0]         bad_ins_count
);
    import cop_pkg::*;

    cop_dec_t dec;
    cop_exe_t exe;

    cop_decode u_decode (
        .vtx_clk     (vtx_clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_enc   (instr_enc),
        .instr_rs1   (instr_rs1),
        .dec         (dec)
    );

    cop_execute u_execute (
        .vtx_clk (vtx_clk),
        .reset   (reset),
        .dec     (dec),
        .exe     (exe)
    );

    cop_result u_result (
        .vtx_clk (vtx_clk),
        .reset   (reset),
        .exe     (exe),
        .trace   (trace)
    );

    cop_retire_check u_retire_check (
        .vtx_clk       (vtx_clk),
        .reset         (reset),
        .trace         (trace),
        .check_fault   (check_fault),
        .bad_ins_count (bad_ins_count)
    );

endmodule

/* rtl/cop_retire_check.sv */
/*
 * Retirement trace checker.
 * Flags a sticky fault when a retired result code is outside the legal
 * set or when BAD_INS disagrees with the decoder's invalid flag.
 * Also counts BAD_INS retirements, saturating at the counter width.
 */
`timescale 1ns/10ps

module cop_retire_check (
    input  logic                vtx_clk,
    input  logic                reset,
    input  cop_pkg::cop_trace_t trace,
    output logic                check_fault,
    output logic [15:0]         bad_ins_count
);
    import cop_pkg::*;

    logic result_legal;
    logic bad_ins_seen;
    logic bad_ins_mismatch;
    logic violation;

    // Every code the full extension may produce
    assign result_legal = trace.result inside {
        SUCCESS, ABORT, BAD_INS, BAD_LAD, BAD_SAD, LD_ERR, ST_ERR
    };

    assign bad_ins_seen     = (trace.result == BAD_INS);
    assign bad_ins_mismatch = (bad_ins_seen != trace.invalid);
    assign violation        = trace.valid && (!result_legal || bad_ins_mismatch);

    always_ff @(posedge vtx_clk) begin
        if (reset) begin
            check_fault <= 1'b0;
        end else if (violation) begin
            check_fault <= 1'b1;
        end
    end

    always_ff @(posedge vtx_clk) begin
        if (reset) begin
            bad_ins_count <= 16'd0;
        end else if (trace.valid && bad_ins_seen && (bad_ins_count != 16'hffff)) begin
            bad_ins_count <= bad_ins_count + 16'd1;
        end
    end

    // Only legal result encodings retire
    a_result_legal: assert property (
        @(posedge vtx_clk) disable iff (reset)
        trace.valid |-> result_legal
    );

    // BAD_INS exactly when the decoder rejected the encoding
    a_bad_ins_matches: assert property (
        @(posedge vtx_clk) disable iff (reset)
        trace.valid |-> (bad_ins_seen == trace.invalid)
    );

endmodule

/* rtl/cop_result.sv */
/*
 * Result stage of the coprocessor pipeline.
 * Turns the execute output into the registered retirement trace.
 * Only mv2gpr writes back to the host register file.
 */
`timescale 1ns/10ps

module cop_result (
    input  logic                vtx_clk,
    input  logic                reset,
    input  cop_pkg::cop_exe_t   exe,
    output cop_pkg::cop_trace_t trace
);
    import cop_pkg::*;

    cop_trace_t trace_next;
    logic       host_wen;

    assign host_wen = exe.valid && !exe.invalid && (exe.op == OP_MV2GPR);

    always_comb begin
        trace_next         = '0;
        trace_next.valid   = exe.valid;
        trace_next.result  = exe.invalid ? BAD_INS : SUCCESS;
        trace_next.wen     = host_wen;
        trace_next.invalid = exe.invalid;
        // Write fields stay zero unless the host register is written
        if (host_wen) begin
            trace_next.waddr = exe.rd;
            trace_next.wdata = exe.wdata;
        end
    end

    always_ff @(posedge vtx_clk) begin
        if (reset) begin
            trace.valid <= 1'b0;
            trace.wen   <= 1'b0;
        end else begin
            trace <= trace_next;
        end
    end

    // A host write only ever retires as a success
    a_wen_success: assert property (
        @(posedge vtx_clk) disable iff (reset)
        trace.wen |-> (trace.valid && trace.result == SUCCESS)
    );

endmodule

/* rtl/cop_execute.sv */
/*
 * Execute stage of the coprocessor pipeline.
 * Holds the sixteen coprocessor registers, reads the source operands
 * and computes the move, add, xor and rotate results. The register
 * write lands on the same edge that hands the result to the next stage.
 */
`timescale 1ns/10ps

module cop_execute (
    input  logic              vtx_clk,
    input  logic              reset,
    input  cop_pkg::cop_dec_t dec,
    output cop_pkg::cop_exe_t exe
);
    import cop_pkg::*;

    logic [cop_num_cprs-1:0][31:0] cprs;
    logic [31:0]                   crs1_data;
    logic [31:0]                   crs2_data;
    logic [63:0]                   rot_wide;
    logic [31:0]                   result_data;
    logic                          cpr_wen;
    cop_exe_t                      exe_next;

    // Operand reads
    assign crs1_data = cprs[dec.crs1];
    assign crs2_data = cprs[dec.crs2];

    // Right rotation through a doubled copy of the operand
    assign rot_wide = {crs1_data, crs1_data} >> dec.imm;

    always_comb begin
        case (dec.op)
            OP_MV2COP: result_data = dec.rs1_value;
            OP_MV2GPR: result_data = crs1_data;
            OP_PADD:   result_data = crs1_data + crs2_data;
            OP_PXOR:   result_data = crs1_data ^ crs2_data;
            OP_PROT:   result_data = rot_wide[31:0];
            default:   result_data = 32'd0;
        endcase
    end

    // Everything but mv2gpr targets a coprocessor register
    assign cpr_wen = dec.valid && !dec.invalid && (dec.op != OP_MV2GPR);

    always_ff @(posedge vtx_clk) begin
        if (reset) begin
            cprs <= '0;
        end else if (cpr_wen) begin
            cprs[dec.crd] <= result_data;
        end
    end

    always_comb begin
        exe_next         = '0;
        exe_next.valid   = dec.valid;
        exe_next.invalid = dec.invalid;
        exe_next.op      = dec.op;
        exe_next.wdata   = result_data;
        exe_next.rd      = dec.rd;
    end

    always_ff @(posedge vtx_clk) begin
        if (reset) begin
            exe.valid <= 1'b0;
        end else begin
            exe <= exe_next;
        end
    end

    // Register file must be untouched by an invalid instruction
    a_invalid_no_write: assert property (
        @(posedge vtx_clk) disable iff (reset)
        (dec.valid && dec.invalid) |=> $stable(cprs)
    );

endmodule

/* rtl/cop_decode.sv */
/*
 * Decode stage of the coprocessor pipeline.
 * Views each incoming encoding in both register and immediate form,
 * matches it against custom-0 and registers the decoded fields.
 * Unmatched encodings leave with op OP_NONE and the invalid flag set.
 */
`timescale 1ns/10ps

module cop_decode (
    input  logic              vtx_clk,
    input  logic              reset,
    input  logic              instr_valid,
    input  logic [31:0]       instr_enc,
    input  logic [31:0]       instr_rs1,
    output cop_pkg::cop_dec_t dec
);
    import cop_pkg::*;

    cop_instr_u instr;
    cop_dec_t   dec_next;
    logic       is_custom;
    logic       rtype_legal;
    logic       itype_legal;

    assign instr     = instr_enc;
    assign is_custom = (instr.rtype.opcode == cop_opcode_custom);

    // Legal shapes of the two formats, judged apart from the op match
    assign rtype_legal = (instr.rtype.funct7 == 7'd0) &&
                         (instr.rtype.funct3 inside {cop_funct_mv2cop, cop_funct_mv2gpr,
                                                     cop_funct_padd, cop_funct_pxor});
    assign itype_legal = (instr.itype.funct3 == cop_funct_prot) &&
                         (instr.itype.imm[11:5] == 7'd0);

    always_comb begin
        dec_next           = '0;
        dec_next.valid     = instr_valid;
        dec_next.crd       = instr.rtype.crd[cop_cpr_aw-1:0];
        dec_next.crs1      = instr.rtype.crs1[cop_cpr_aw-1:0];
        dec_next.crs2      = instr.rtype.crs2[cop_cpr_aw-1:0];
        // Rotate amount comes from the immediate view of the same bits
        dec_next.imm       = instr.itype.imm[4:0];
        dec_next.rs1_value = instr_rs1;
        dec_next.rd        = instr.rtype.crd;
        dec_next.op        = OP_NONE;

        if (is_custom) begin
            case (instr.rtype.funct3)
                cop_funct_mv2cop: begin
                    if (instr.rtype.funct7 == 7'd0) begin
                        dec_next.op = OP_MV2COP;
                    end
                end
                cop_funct_mv2gpr: begin
                    if (instr.rtype.funct7 == 7'd0) begin
                        dec_next.op = OP_MV2GPR;
                    end
                end
                cop_funct_padd: begin
                    if (instr.rtype.funct7 == 7'd0) begin
                        dec_next.op = OP_PADD;
                    end
                end
                cop_funct_pxor: begin
                    if (instr.rtype.funct7 == 7'd0) begin
                        dec_next.op = OP_PXOR;
                    end
                end
                cop_funct_prot: begin
                    // Only a 5-bit rotate amount is legal
                    if (instr.itype.imm[11:5] == 7'd0) begin
                        dec_next.op = OP_PROT;
                    end
                end
                default: begin
                    dec_next.op = OP_NONE;
                end
            endcase
        end

        dec_next.invalid = !(is_custom && (rtype_legal || itype_legal));
    end

    always_ff @(posedge vtx_clk) begin
        if (reset) begin
            dec.valid <= 1'b0;
        end else begin
            dec <= dec_next;
        end
    end

    // An invalid instruction never carries a real operation downstream,
    // and a legal one always carries its operation
    a_invalid_no_op: assert property (
        @(posedge vtx_clk) disable iff (reset)
        dec.valid |-> (dec.invalid == (dec.op == OP_NONE))
    );

endmodule

/* rtl/cop_pkg.sv */
/*
 * Shared definitions for the crypto coprocessor slice.
 * Holds the custom-0 encodings, result codes, the two instruction views
 * and the structs passed between the decode, execute and result stages.
 */
package cop_pkg;

    // Register file geometry
    localparam int cop_num_cprs = 16;
    localparam int cop_cpr_aw   = $clog2(cop_num_cprs);

    // Major opcode of the extension (custom-0)
    localparam logic [6:0] cop_opcode_custom = 7'b0001011;

    // funct3 selects the instruction within custom-0
    localparam logic [2:0] cop_funct_mv2cop = 3'b000;
    localparam logic [2:0] cop_funct_mv2gpr = 3'b001;
    localparam logic [2:0] cop_funct_padd   = 3'b010;
    localparam logic [2:0] cop_funct_pxor   = 3'b011;
    localparam logic [2:0] cop_funct_prot   = 3'b100;

    // Retirement result codes, value 7 is unused
    typedef enum logic [2:0] {
        SUCCESS = 3'd0,
        ABORT   = 3'd1,
        BAD_INS = 3'd2,
        BAD_LAD = 3'd3,
        BAD_SAD = 3'd4,
        LD_ERR  = 3'd5,
        ST_ERR  = 3'd6
    } cop_result_t;

    // Register format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] crs2;
        logic [4:0] crs1;
        logic [2:0] funct3;
        logic [4:0] crd;
        logic [6:0] opcode;
    } cop_rtype_t;

    // Immediate format, imm overlays funct7 and crs2
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  crs1;
        logic [2:0]  funct3;
        logic [4:0]  crd;
        logic [6:0]  opcode;
    } cop_itype_t;

    typedef union packed {
        cop_rtype_t rtype;
        cop_itype_t itype;
    } cop_instr_u;

    typedef enum logic [2:0] {
        OP_MV2COP,
        OP_MV2GPR,
        OP_PADD,
        OP_PXOR,
        OP_PROT,
        OP_NONE
    } cop_op_t;

    // Decode to execute
    typedef struct packed {
        logic                  valid;
        cop_op_t               op;
        logic                  invalid;
        logic [cop_cpr_aw-1:0] crd;
        logic [cop_cpr_aw-1:0] crs1;
        logic [cop_cpr_aw-1:0] crs2;
        logic [4:0]            imm;
        logic [31:0]           rs1_value;
        logic [4:0]            rd;
    } cop_dec_t;

    // Execute to result
    typedef struct packed {
        logic        valid;
        logic        invalid;
        cop_op_t     op;
        logic [31:0] wdata;
        logic [4:0]  rd;
    } cop_exe_t;

    // Retirement trace seen by the host and the checker
    typedef struct packed {
        logic        valid;
        cop_result_t result;
        logic [31:0] wdata;
        logic [4:0]  waddr;
        logic        wen;
        logic        invalid;
    } cop_trace_t;

endpackage
